// File: sim.f
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/register_bank.sv
hdl/ram.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/writeback.sv
hdl/cpu.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pipe_pkg::*;

    localparam logic [31:0] reset_pc = 32'h0000_0000;
    localparam int num_tests = 5;
    localparam int timeout_cycles = 60 * num_tests;

    logic        clock;
    logic        rst_n;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    retire_t     retire;

    logic [31:0] rom [64];
    retire_t     exp_q [$];
    retire_t     got_q [$];
    int          prog_len;
    int          cycle_count;
    logic [31:0] rng_state;

    cpu #(
        .RESET_PC (reset_pc),
        .RAM_WORDS(64)
    ) i_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .enable     (enable),
        .rom_data   (rom_data),
        .rom_address(rom_address),
        .retire     (retire)
    );

    assign rom_data = rom[rom_address[7:2]];   // Combinational ROM

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1, "run exceeded its cycle budget");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Signed order from the sign bits, unsigned order when they agree
    function automatic logic [31:0] set_less_than(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31])
            return {31'b0, a[31]};
        return {31'b0, a < b};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // RV32I encodings
    function automatic logic [31:0] op_instr(input logic [2:0] f3, input logic [6:0] f7,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_instr(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 64; i++)
            rom[i] = addi_instr(5'd0, 5'd0, 12'(i));   // ADDI x0 tagged with its index
        exp_q.delete();
        prog_len = 0;
    endtask

    // Places one word and, if it commits, its expected retire record
    task automatic emit(input logic [31:0] instr, input bit retires, input logic [4:0] rd,
                        input logic [31:0] data, input bit store);
        retire_t rec;
        rec.valid = 1'b1;
        rec.pc    = reset_pc + 32'(4 * prog_len);
        rec.rd    = rd;
        rec.data  = data;
        rec.store = store;
        rom[prog_len] = instr;
        if (retires)
            exp_q.push_back(rec);
        prog_len++;
    endtask

    task automatic emit_nops(input int count);
        repeat (count)
            emit(addi_instr(5'd0, 5'd0, 12'd0), 1'b1, 5'd0, 32'd0, 1'b0);
    endtask

    task automatic run_program(input int stall_start, input int stall_len, input bit trace_pc,
                               output int first_retire);
        int cycle;
        cycle = 0;
        first_retire = -1;
        got_q.delete();
        rst_n  = 1'b0;
        enable = 1'b1;
        repeat (4)
            @(posedge clock);
        #2;
        rst_n = 1'b1;
        check_equal(rom_address, reset_pc, "rom_address after reset");
        while (got_q.size() < exp_q.size()) begin
            @(negedge clock);
            if (trace_pc && cycle < 8)
                check_equal(rom_address, reset_pc + 32'(4 * cycle), "sequential rom_address");
            if (retire.valid && enable) begin   // Commits on the coming edge
                if (first_retire < 0)
                    first_retire = cycle;
                got_q.push_back(retire);
            end
            @(posedge clock);
            #2;
            cycle++;
            enable = !(cycle >= stall_start && cycle < stall_start + stall_len);
        end
        foreach (exp_q[i]) begin
            check_equal(got_q[i].pc, exp_q[i].pc, $sformatf("retire %0d pc", i));
            check_equal(32'(got_q[i].rd), 32'(exp_q[i].rd), $sformatf("retire %0d rd", i));
            check_equal(32'(got_q[i].store), 32'(exp_q[i].store),
                        $sformatf("retire %0d store", i));
            if (exp_q[i].rd != '0)
                check_equal(got_q[i].data, exp_q[i].data, $sformatf("retire %0d data", i));
        end
    endtask

    task automatic build_memory_program();
        clear_program();
        emit(addi_instr(5'd1, 5'd0, 12'h040), 1'b1, 5'd1, 32'h40, 1'b0);
        emit(lui_instr(5'd2, 20'h12345), 1'b1, 5'd2, 32'h1234_5000, 1'b0);
        emit_nops(3);
        emit(addi_instr(5'd2, 5'd2, 12'h678), 1'b1, 5'd2, 32'h1234_5678, 1'b0);
        emit_nops(3);
        emit(sw_instr(5'd2, 5'd1, 12'd4), 1'b1, 5'd0, 32'd0, 1'b1);
        emit(lw_instr(5'd3, 5'd1, 12'd4), 1'b1, 5'd3, 32'h1234_5678, 1'b0);
        emit(lw_instr(5'd4, 5'd1, 12'd8), 1'b1, 5'd4, 32'd0, 1'b0);   // Cleared by reset
    endtask

    task automatic build_branch_program();
        clear_program();
        emit(addi_instr(5'd1, 5'd0, 12'd7), 1'b1, 5'd1, 32'd7, 1'b0);
        emit(addi_instr(5'd2, 5'd0, 12'd7), 1'b1, 5'd2, 32'd7, 1'b0);
        emit(addi_instr(5'd3, 5'd0, 12'd9), 1'b1, 5'd3, 32'd9, 1'b0);
        emit_nops(3);
        emit(beq_instr(5'd1, 5'd3, 13'd16), 1'b1, 5'd0, 32'd0, 1'b0);   // 7 != 9
        emit(addi_instr(5'd4, 5'd0, 12'd1), 1'b1, 5'd4, 32'd1, 1'b0);
        emit(addi_instr(5'd5, 5'd0, 12'd2), 1'b1, 5'd5, 32'd2, 1'b0);
        emit(addi_instr(5'd6, 5'd0, 12'd3), 1'b1, 5'd6, 32'd3, 1'b0);
        emit(beq_instr(5'd1, 5'd2, 13'd24), 1'b1, 5'd0, 32'd0, 1'b0);   // Taken to word 16
        for (int i = 11; i < 16; i++)
            emit(addi_instr(5'(i), 5'd0, 12'hbad), 1'b0, 5'(i), 32'hffff_fbad, 1'b0);
        emit(addi_instr(5'd16, 5'd0, 12'h055), 1'b1, 5'd16, 32'h55, 1'b0);
    endtask

    task automatic test_reset_sequence();
        int first;
        clear_program();
        emit(addi_instr(5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'd5, 1'b0);
        emit(addi_instr(5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hffff_fffd, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b000, 7'h00, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'd2, 1'b0);
        run_program(0, 0, 1'b1, first);
        check_equal(first, 4, "cycles from address 0 to first retire");
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] a_hi;
        logic [31:0] b_hi;
        int first;
        rng_state = xorshift(rng_state);
        a = rng_state;
        rng_state = xorshift(rng_state);
        b = rng_state;
        a_hi = (a + 32'h800) & 32'hffff_f000;   // Offsets the sign of the ADDI part
        b_hi = (b + 32'h800) & 32'hffff_f000;
        clear_program();
        emit(lui_instr(5'd1, a_hi[31:12]), 1'b1, 5'd1, a_hi, 1'b0);
        emit(lui_instr(5'd2, b_hi[31:12]), 1'b1, 5'd2, b_hi, 1'b0);
        emit_nops(2);
        emit(addi_instr(5'd1, 5'd1, a[11:0]), 1'b1, 5'd1, a, 1'b0);
        emit(addi_instr(5'd2, 5'd2, b[11:0]), 1'b1, 5'd2, b, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b000, 7'h00, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, a + b, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b000, 7'h20, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, a - b, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b111, 7'h00, 5'd5, 5'd1, 5'd2), 1'b1, 5'd5, a & b, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b110, 7'h00, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, a | b, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b100, 7'h00, 5'd7, 5'd1, 5'd2), 1'b1, 5'd7, a ^ b, 1'b0);
        emit_nops(3);
        emit(op_instr(3'b010, 7'h00, 5'd8, 5'd1, 5'd2), 1'b1, 5'd8,
             set_less_than(a, b), 1'b0);
        run_program(0, 0, 1'b0, first);
    endtask

    task automatic test_memory();
        int first;
        build_memory_program();
        run_program(0, 0, 1'b0, first);
    endtask

    task automatic test_branches();
        int first;
        build_branch_program();
        run_program(0, 0, 1'b0, first);
    endtask

    // Stalls across the store/load pair and across the redirect cycle
    task automatic test_enable_hold();
        int first;
        build_memory_program();
        run_program(11, 3, 1'b0, first);
        build_branch_program();
        run_program(13, 4, 1'b0, first);
    endtask

    initial begin
        rst_n       = 1'b0;
        enable      = 1'b0;
        cycle_count = 0;
        rng_state   = 32'hb788;
        clear_program();
        test_reset_sequence();
        test_alu_ops();
        test_memory();
        test_branches();
        test_enable_hold();
        if (i_dut.i_cpu_assert.failure_count != 0) begin
            $display("Bound assertions failed %0d times", i_dut.i_cpu_assert.failure_count);
            $display("Simulation failed");
            $fatal(1, "assertion failures during the run");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  enable,
    input logic [31:0]           rom_address,
    input cpu_pipe_pkg::retire_t retire,
    input logic                  rf_write_enable,
    input cpu_isa_pkg::reg_idx_t rf_write_idx
);

    int failure_count = 0;   // Read by the testbench at the end of the run

    // Four stage registers must fill before anything commits
    retire_quiet_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> !retire.valid [*4])
    else begin
        failure_count = failure_count + 1;
        $error("retire.valid high within four cycles of reset release");
    end

    pc_held_without_enable: assert property (@(posedge clock) disable iff (!rst_n)
        !enable |=> $stable(rom_address))
    else begin
        failure_count = failure_count + 1;
        $error("rom_address moved while enable was low");
    end

    // Decode drops the write of any instruction aimed at x0
    no_write_to_x0: assert property (@(posedge clock) disable iff (!rst_n)
        rf_write_enable |-> (rf_write_idx != '0))
    else begin
        failure_count = failure_count + 1;
        $error("register write to x0");
    end

endmodule

bind cpu cpu_assert i_cpu_assert (
    .clock          (clock),
    .rst_n          (rst_n),
    .enable         (enable),
    .rom_address    (rom_address),
    .retire         (retire),
    .rf_write_enable(rf_write_enable),
    .rf_write_idx   (rf_write_idx)
);

`default_nettype wire

// File: hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter logic [31:0] RESET_PC  = 32'h0000_0000,
    parameter int          RAM_WORDS = 256
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [31:0]           rom_data,
    output logic [31:0]           rom_address,
    output cpu_pipe_pkg::retire_t retire
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    // Stage registers
    if_de_t  if_de;
    de_ex_t  de_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // Register bank
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rf_write_idx;
    word_t    rs1_value;
    word_t    rs2_value;
    word_t    rf_write_value;
    logic     rf_write_enable;

    // Data RAM
    word_t ram_address;
    word_t ram_write_data;
    word_t ram_read_data;
    logic  ram_write;

    // Branch redirect from the memory stage
    logic  redirect;
    word_t redirect_target;

    fetch #(
        .RESET_PC(RESET_PC)
    ) i_fetch (
        .clk            (clock),
        .rst_n          (rst_n),
        .enable         (enable),
        .flush          (redirect),
        .redirect_target(redirect_target),
        .rom_data       (rom_data),
        .rom_address    (rom_address),
        .if_de          (if_de)
    );

    decode i_decode (
        .clk      (clock),
        .rst_n    (rst_n),
        .enable   (enable),
        .flush    (redirect),
        .if_de    (if_de),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .de_ex    (de_ex)
    );

    execute i_execute (
        .clk   (clock),
        .rst_n (rst_n),
        .enable(enable),
        .flush (redirect),
        .de_ex (de_ex),
        .ex_mem(ex_mem)
    );

    memory i_memory (
        .clk            (clock),
        .rst_n          (rst_n),
        .enable         (enable),
        .ex_mem         (ex_mem),
        .ram_read_data  (ram_read_data),
        .ram_address    (ram_address),
        .ram_write_data (ram_write_data),
        .ram_write      (ram_write),
        .redirect       (redirect),
        .redirect_target(redirect_target),
        .mem_wb         (mem_wb)
    );

    writeback i_writeback (
        .mem_wb      (mem_wb),
        .write_enable(rf_write_enable),
        .write_idx   (rf_write_idx),
        .write_value (rf_write_value),
        .retire      (retire)
    );

    // Commit happens on the edge where enable is high
    register_bank i_register_bank (
        .clk         (clock),
        .rst_n       (rst_n),
        .write_enable(rf_write_enable & enable),
        .write_idx   (rf_write_idx),
        .write_value (rf_write_value),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value)
    );

    ram #(
        .RAM_WORDS(RAM_WORDS)
    ) i_ram (
        .clk       (clock),
        .rst_n     (rst_n),
        .address   (ram_address),
        .write_data(ram_write_data),
        .write     (ram_write),
        .read_data (ram_read_data)
    );

endmodule

`default_nettype wire

// File: hdl/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  cpu_pipe_pkg::mem_wb_t mem_wb,
    output logic                  write_enable,
    output cpu_isa_pkg::reg_idx_t write_idx,
    output logic [31:0]           write_value,
    output cpu_pipe_pkg::retire_t retire
);

    assign write_enable = mem_wb.ctrl.valid && mem_wb.ctrl.reg_write;
    assign write_idx    = mem_wb.ctrl.rd;
    assign write_value  = mem_wb.wb_data;

    // One record per valid instruction, stores and branches included
    always_comb begin
        retire.valid = mem_wb.ctrl.valid;
        retire.pc    = mem_wb.pc;
        retire.rd    = mem_wb.ctrl.rd;    // Zero when nothing is written
        retire.data  = mem_wb.wb_data;
        retire.store = mem_wb.ctrl.mem_write;
    end

endmodule

`default_nettype wire

// File: hdl/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  cpu_pipe_pkg::ex_mem_t ex_mem,
    input  logic [31:0]           ram_read_data,
    output logic [31:0]           ram_address,
    output logic [31:0]           ram_write_data,
    output logic                  ram_write,
    output logic                  redirect,
    output logic [31:0]           redirect_target,
    output cpu_pipe_pkg::mem_wb_t mem_wb
);
    import cpu_isa_pkg::*;

    word_t wb_data;

    assign ram_address    = ex_mem.result;      // Address from the ALU
    assign ram_write_data = ex_mem.store_data;
    assign ram_write      = ex_mem.ctrl.valid && ex_mem.ctrl.mem_write && enable;

    // Also serves as the flush of the three younger stages
    assign redirect        = ex_mem.ctrl.valid && ex_mem.take_branch;
    assign redirect_target = ex_mem.branch_target;

    assign wb_data = ex_mem.ctrl.mem_read ? ram_read_data : ex_mem.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (enable) begin
            mem_wb.ctrl    <= ex_mem.ctrl;
            mem_wb.pc      <= ex_mem.pc;
            mem_wb.wb_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  flush,
    input  cpu_pipe_pkg::de_ex_t  de_ex,
    output cpu_pipe_pkg::ex_mem_t ex_mem
);
    import cpu_isa_pkg::*;

    word_t operand_a;
    word_t operand_b;
    word_t alu_result;
    word_t branch_target;
    logic  take_branch;

    assign operand_a = de_ex.rs1_value;
    assign operand_b = de_ex.ctrl.alu_src ? de_ex.imm : de_ex.rs2_value;

    always_comb begin
        case (de_ex.ctrl.alu_op)
            alu_add:    alu_result = operand_a + operand_b;
            alu_sub:    alu_result = operand_a - operand_b;
            alu_and:    alu_result = operand_a & operand_b;
            alu_or:     alu_result = operand_a | operand_b;
            alu_xor:    alu_result = operand_a ^ operand_b;
            alu_slt:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            alu_pass_b: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // BEQ compares the raw register values, not operand_b
    assign branch_target = de_ex.pc + de_ex.imm;
    assign take_branch   = de_ex.ctrl.valid && de_ex.ctrl.branch
                           && (de_ex.rs1_value == de_ex.rs2_value);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (enable) begin
            if (flush) begin
                ex_mem <= '0;
            end else begin
                ex_mem.ctrl          <= de_ex.ctrl;
                ex_mem.pc            <= de_ex.pc;
                ex_mem.result        <= alu_result;
                ex_mem.store_data    <= de_ex.rs2_value;
                ex_mem.branch_target <= branch_target;
                ex_mem.take_branch   <= take_branch;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  flush,
    input  cpu_pipe_pkg::if_de_t  if_de,
    input  logic [31:0]           rs1_value,
    input  logic [31:0]           rs2_value,
    output cpu_isa_pkg::reg_idx_t rs1_idx,
    output cpu_isa_pkg::reg_idx_t rs2_idx,
    output cpu_pipe_pkg::de_ex_t  de_ex
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    opcode_e      opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    reg_idx_t     rd;
    instr_class_e iclass;
    logic         legal;
    word_t        imm;
    ctrl_t        ctrl;

    assign opcode  = opcode_e'(if_de.instr[6:0]);
    assign rd      = if_de.instr[11:7];
    assign funct3  = if_de.instr[14:12];
    assign funct7  = if_de.instr[31:25];
    assign rs1_idx = if_de.instr[19:15];
    assign rs2_idx = if_de.instr[24:20];

    always_comb begin
        ctrl   = '0;
        iclass = cls_none;
        legal  = 1'b0;
        case (opcode)
            opc_op: begin
                iclass         = cls_r;
                legal          = 1'b1;
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {f7_base, f3_add_sub}: ctrl.alu_op = alu_add;
                    {f7_alt,  f3_add_sub}: ctrl.alu_op = alu_sub;
                    {f7_base, f3_slt}:     ctrl.alu_op = alu_slt;
                    {f7_base, f3_xor}:     ctrl.alu_op = alu_xor;
                    {f7_base, f3_or}:      ctrl.alu_op = alu_or;
                    {f7_base, f3_and}:     ctrl.alu_op = alu_and;
                    default:               legal = 1'b0;
                endcase
            end
            opc_op_imm: begin   // ADDI only
                iclass         = cls_i;
                legal          = (funct3 == f3_add_sub);
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            opc_lui: begin
                iclass         = cls_u;
                legal          = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_pass_b;
            end
            opc_load: begin
                iclass         = cls_i;
                legal          = (funct3 == f3_word);
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            opc_store: begin
                iclass         = cls_s;
                legal          = (funct3 == f3_word);
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            opc_branch: begin
                iclass      = cls_b;
                legal       = (funct3 == f3_beq);
                ctrl.branch = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        // x0 as destination keeps the instruction but drops the write
        ctrl.reg_write = ctrl.reg_write && (rd != '0);
        ctrl.rd        = ctrl.reg_write ? rd : '0;
        ctrl.valid     = legal && if_de.valid;
        if (!ctrl.valid)
            ctrl = '0;
    end

    always_comb begin
        case (iclass)
            cls_i:   imm = {{20{if_de.instr[31]}}, if_de.instr[31:20]};
            cls_s:   imm = {{20{if_de.instr[31]}}, if_de.instr[31:25], if_de.instr[11:7]};
            cls_b:   imm = {{19{if_de.instr[31]}}, if_de.instr[31], if_de.instr[7],
                            if_de.instr[30:25], if_de.instr[11:8], 1'b0};
            cls_u:   imm = {if_de.instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_ex <= '0;
        end else if (enable) begin
            if (flush) begin
                de_ex <= '0;
            end else begin
                de_ex.ctrl      <= ctrl;
                de_ex.pc        <= if_de.pc;
                de_ex.imm       <= imm;
                de_ex.rs1_value <= rs1_value;
                de_ex.rs2_value <= rs2_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 flush,
    input  logic [31:0]          redirect_target,
    input  logic [31:0]          rom_data,
    output logic [31:0]          rom_address,
    output cpu_pipe_pkg::if_de_t if_de
);

    logic [31:0] pc;

    assign rom_address = pc;   // ROM answers in the same cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            if_de <= '0;
        end else if (enable) begin
            if (flush) begin
                // Word at pc is on the wrong path
                pc    <= redirect_target;
                if_de <= '0;
            end else begin
                pc          <= pc + 32'd4;
                if_de.valid <= 1'b1;
                if_de.pc    <= pc;
                if_de.instr <= rom_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] address,
    input  logic [31:0] write_data,
    input  logic        write,
    output logic [31:0] read_data
);
    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // Byte address to word index, wrapped to the array depth
    assign word_idx = IDX_W'(address[31:2] % RAM_WORDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < RAM_WORDS; i++)
                mem[i] <= '0;
        end else if (write) begin
            mem[word_idx] <= write_data;
        end
    end

    assign read_data = mem[word_idx];   // Combinational read

endmodule

`default_nettype wire

// File: hdl/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  write_enable,
    input  cpu_isa_pkg::reg_idx_t write_idx,
    input  logic [31:0]           write_value,
    input  cpu_isa_pkg::reg_idx_t rs1_idx,
    input  cpu_isa_pkg::reg_idx_t rs2_idx,
    output logic [31:0]           rs1_value,
    output logic [31:0]           rs2_value
);
    import cpu_isa_pkg::*;

    word_t regs [32];

    // Bypass the write in flight so decode sees it in the same cycle
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (write_enable && (idx == write_idx))
            return write_value;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_enable && (write_idx != '0)) begin
            regs[write_idx] <= write_value;
        end
    end

    always_comb begin
        rs1_value = read_port(rs1_idx);
        rs2_value = read_port(rs2_idx);
    end

endmodule

`default_nettype wire

// File: hdl/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // Control bundle that follows an instruction down the pipe
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        alu_op_e  alu_op;
        logic     alu_src;   // Immediate as operand b
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_de_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t imm;
        word_t rs1_value;
        word_t rs2_value;
    } de_ex_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t result;
        word_t store_data;
        word_t branch_target;
        logic  take_branch;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t wb_data;
    } mem_wb_t;

    // Commit record seen outside the core
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
        logic     store;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b  // LUI
    } alu_op_e;

    // Instruction format, selects the immediate layout
    typedef enum logic [2:0] {
        cls_none,
        cls_r,
        cls_i,
        cls_s,
        cls_b,
        cls_u
    } instr_class_e;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010; // LW / SW
    localparam logic [2:0] f3_beq     = 3'b000;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // SUB

endpackage

`default_nettype wire
